/* hw/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define DATA_WIDTH 32
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// primary opcodes, bits 31:26 of the instruction
`define OP_RTYPE 6'd0
`define OP_ADDI 6'd8
`define OP_ANDI 6'd12
`define OP_ORI 6'd13
`define OP_LUI 6'd15

`define FN_ADD 6'd32
`define FN_SUB 6'd34
`define FN_AND 6'd36
`define FN_OR 6'd37
`define FN_XOR 6'd38
`define FN_SLT 6'd42
`define FN_SLL 6'd0
`define FN_SRL 6'd2

`endif

/* hw/cpuPkg.sv */
`include "cpu_defs.svh"

package cpuPkg;

	typedef enum logic [3:0] {
		opAdd,
		opSub,
		opAnd,
		opOr,
		opXor,
		opSlt,
		opSll,
		opSrl,
		opLui
	} aluOpT;

	typedef struct packed {
		aluOpT aluOp;
		logic [`REG_ADDR_WIDTH-1:0] srcA;
		logic [`REG_ADDR_WIDTH-1:0] srcB;
		logic [`DATA_WIDTH-1:0] opA; // register file value for srcA
		logic [`DATA_WIDTH-1:0] opB; // register file value for srcB
		logic useImm;
		logic [`DATA_WIDTH-1:0] imm; // already extended
		logic [4:0] shamt;
		logic [`REG_ADDR_WIDTH-1:0] dest;
		logic regWrite;
		logic illegal;
	} decodedT;

	typedef struct packed {
		logic [`REG_ADDR_WIDTH-1:0] dest;
		logic [`DATA_WIDTH-1:0] data;
		logic regWrite;
		logic illegal;
	} wbT;

endpackage

/* hw/registerFile.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module registerFile (
	input logic clock,
	input logic rst,
	input logic [`REG_ADDR_WIDTH-1:0] readSelA,
	input logic [`REG_ADDR_WIDTH-1:0] readSelB,
	input logic [`REG_ADDR_WIDTH-1:0] writeSel,
	input logic [`DATA_WIDTH-1:0] writeData,
	input logic we,
	output logic [`DATA_WIDTH-1:0] readOutA,
	output logic [`DATA_WIDTH-1:0] readOutB
);

	logic [`DATA_WIDTH-1:0] mem [1:`REG_COUNT-1]; // register 0 has no storage

	// writes land mid-cycle so a read later in the same cycle sees them
	always_ff @(negedge clock)
	begin
		if (rst)
		begin
			for (int i = 1; i < `REG_COUNT; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (we && (writeSel != '0))
		begin
			mem[writeSel] <= writeData;
		end
	end

	always_comb
	begin
		if (readSelA == '0)
			readOutA = '0;
		else
			readOutA = mem[readSelA];
	end

	always_comb
	begin
		if (readSelB == '0)
			readOutB = '0;
		else
			readOutB = mem[readSelB];
	end

	// the enable comes from the result stage register, so it must be clean after reset
	weKnown: assert property (@(negedge clock) disable iff (rst) !$isunknown(we))
		else $error("register file write enable is unknown");

endmodule

/* hw/pipeStage.sv */
`timescale 1ns/1ps

module pipeStage #(
	parameter type payloadT = logic
) (
	input logic clock,
	input logic rst,
	input logic inValid,
	input payloadT inData,
	output logic outValid,
	output payloadT outData
);

	always_ff @(posedge clock)
	begin
		if (rst)
			outValid <= 1'b0;
		else
			outValid <= inValid;
	end

	// payload only moves with a valid beat
	always_ff @(posedge clock)
	begin
		if (inValid)
			outData <= inData;
	end

endmodule

/* hw/instrDecoder.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module instrDecoder
	import cpuPkg::*;
(
	input logic clock,
	input logic rst,
	input logic [`DATA_WIDTH-1:0] instr,
	input logic instrValid,
	input logic [`DATA_WIDTH-1:0] readOutA,
	input logic [`DATA_WIDTH-1:0] readOutB,
	output logic [`REG_ADDR_WIDTH-1:0] readSelA,
	output logic [`REG_ADDR_WIDTH-1:0] readSelB,
	output decodedT decoded,
	output logic decodedValid
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [`REG_ADDR_WIDTH-1:0] rs;
	logic [`REG_ADDR_WIDTH-1:0] rt;
	logic [`REG_ADDR_WIDTH-1:0] rd;
	logic [15:0] imm16;
	decodedT decodeNext;

	assign opcode = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign imm16 = instr[15:0];
	assign funct = instr[5:0];

	assign readSelA = rs;
	assign readSelB = rt;

	always_comb
	begin
		decodeNext = '0;
		decodeNext.aluOp = opAdd;
		decodeNext.srcA = rs;
		decodeNext.srcB = rt;
		decodeNext.opA = readOutA;
		decodeNext.opB = readOutB;
		decodeNext.useImm = 1'b1;
		decodeNext.imm = {{(`DATA_WIDTH-16){1'b0}}, imm16}; // zero extension by default
		decodeNext.shamt = instr[10:6];
		decodeNext.dest = rt;
		case (opcode)
			`OP_RTYPE:
			begin
				decodeNext.useImm = 1'b0;
				decodeNext.dest = rd;
				case (funct)
					`FN_ADD: decodeNext.aluOp = opAdd;
					`FN_SUB: decodeNext.aluOp = opSub;
					`FN_AND: decodeNext.aluOp = opAnd;
					`FN_OR: decodeNext.aluOp = opOr;
					`FN_XOR: decodeNext.aluOp = opXor;
					`FN_SLT: decodeNext.aluOp = opSlt;
					`FN_SLL: decodeNext.aluOp = opSll;
					`FN_SRL: decodeNext.aluOp = opSrl;
					default: decodeNext.illegal = 1'b1;
				endcase
			end
			`OP_ADDI: decodeNext.imm = {{(`DATA_WIDTH-16){imm16[15]}}, imm16};
			`OP_ANDI: decodeNext.aluOp = opAnd;
			`OP_ORI: decodeNext.aluOp = opOr;
			`OP_LUI: decodeNext.aluOp = opLui;
			default: decodeNext.illegal = 1'b1;
		endcase
		decodeNext.regWrite = !decodeNext.illegal && (decodeNext.dest != '0); // r0 stays zero
	end

	pipeStage #(
		.payloadT(decodedT)
	) decodeReg_i (
		.clock(clock),
		.rst(rst),
		.inValid(instrValid),
		.inData(decodeNext),
		.outValid(decodedValid),
		.outData(decoded)
	);

endmodule

/* hw/aluExecute.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module aluExecute
	import cpuPkg::*;
(
	input decodedT decoded,
	input logic decodedValid,
	input wbT wb,
	input logic wbValid,
	output wbT exec,
	output logic execValid
);

	logic fwdA;
	logic fwdB;
	logic [`DATA_WIDTH-1:0] opA;
	logic [`DATA_WIDTH-1:0] opB;
	logic [`DATA_WIDTH-1:0] aluIn2;
	logic [`DATA_WIDTH-1:0] aluOut;

	// the instruction one ahead has not reached the register file when decode read it
	assign fwdA = wbValid && wb.regWrite && (wb.dest == decoded.srcA);
	assign fwdB = wbValid && wb.regWrite && (wb.dest == decoded.srcB);
	assign opA = fwdA ? wb.data : decoded.opA;
	assign opB = fwdB ? wb.data : decoded.opB;
	assign aluIn2 = decoded.useImm ? decoded.imm : opB;

	always_comb
	begin
		case (decoded.aluOp)
			opAdd: aluOut = opA + aluIn2; // wraps on overflow
			opSub: aluOut = opA - aluIn2;
			opAnd: aluOut = opA & aluIn2;
			opOr: aluOut = opA | aluIn2;
			opXor: aluOut = opA ^ aluIn2;
			opSlt: aluOut = {{(`DATA_WIDTH-1){1'b0}}, $signed(opA) < $signed(aluIn2)};
			opSll: aluOut = aluIn2 << decoded.shamt;
			opSrl: aluOut = aluIn2 >> decoded.shamt;
			opLui: aluOut = {decoded.imm[15:0], {(`DATA_WIDTH-16){1'b0}}};
			default: aluOut = '0;
		endcase
	end

	always_comb
	begin
		exec.dest = decoded.dest;
		exec.data = decoded.illegal ? '0 : aluOut; // illegal encodings report zero
		exec.regWrite = decoded.regWrite;
		exec.illegal = decoded.illegal;
	end

	assign execValid = decodedValid;

	always_comb
	begin
		if (decodedValid)
			aluOpDefined: assert (decoded.aluOp <= opLui)
				else $error("undefined ALU operation %0d", decoded.aluOp);
	end

endmodule

/* hw/resultStage.sv */
`timescale 1ns/1ps

module resultStage
	import cpuPkg::*;
(
	input logic clock,
	input logic rst,
	input wbT exec,
	input logic execValid,
	output wbT wb,
	output logic wbValid,
	output logic [31:0] retiredCount,
	output logic [31:0] illegalCount
);

	pipeStage #(
		.payloadT(wbT)
	) resultReg_i (
		.clock(clock),
		.rst(rst),
		.inValid(execValid),
		.inData(exec),
		.outValid(wbValid),
		.outData(wb)
	);

	// counters move on the same edge that puts the instruction on the result ports
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			retiredCount <= '0;
			illegalCount <= '0;
		end
		else if (execValid)
		begin
			retiredCount <= retiredCount + 32'd1;
			if (exec.illegal)
				illegalCount <= illegalCount + 32'd1;
		end
	end

	// decode must have dropped the write for every illegal encoding
	noIllegalWrite: assert property (@(posedge clock) disable iff (rst)
		wbValid |-> !(wb.regWrite && wb.illegal))
		else $error("illegal instruction retired with a register write");

endmodule

/* hw/datapathCore.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module datapathCore
	import cpuPkg::*;
(
	input logic clock,
	input logic rst,
	input logic [`DATA_WIDTH-1:0] instr,
	input logic instrValid,
	output wbT result,
	output logic resultValid,
	output logic [31:0] retiredCount,
	output logic [31:0] illegalCount
);

	logic [`REG_ADDR_WIDTH-1:0] readSelA;
	logic [`REG_ADDR_WIDTH-1:0] readSelB;
	logic [`DATA_WIDTH-1:0] readOutA;
	logic [`DATA_WIDTH-1:0] readOutB;
	decodedT decoded;
	logic decodedValid;
	wbT exec;
	logic execValid;

	instrDecoder decoder_i (
		.clock(clock),
		.rst(rst),
		.instr(instr),
		.instrValid(instrValid),
		.readOutA(readOutA),
		.readOutB(readOutB),
		.readSelA(readSelA),
		.readSelB(readSelB),
		.decoded(decoded),
		.decodedValid(decodedValid)
	);

	aluExecute execute_i (
		.decoded(decoded),
		.decodedValid(decodedValid),
		.wb(result), // result stage feeds forwarding
		.wbValid(resultValid),
		.exec(exec),
		.execValid(execValid)
	);

	resultStage result_i (
		.clock(clock),
		.rst(rst),
		.exec(exec),
		.execValid(execValid),
		.wb(result),
		.wbValid(resultValid),
		.retiredCount(retiredCount),
		.illegalCount(illegalCount)
	);

	registerFile regFile_i (
		.clock(clock),
		.rst(rst),
		.readSelA(readSelA),
		.readSelB(readSelB),
		.writeSel(result.dest),
		.writeData(result.data),
		.we(result.regWrite && resultValid),
		.readOutA(readOutA),
		.readOutB(readOutB)
	);

endmodule

/* verif/datapathCore_tb.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module datapathCore_tb
	import cpuPkg::*;
;

	localparam int CLK_PERIOD = 4;
	localparam int TOTAL_INSTR = 520; // sum of the instructions issued by all six tests

	logic clock;
	logic rst;
	logic [31:0] instr;
	logic instrValid;
	wbT result;
	logic resultValid;
	logic [31:0] retiredCount;
	logic [31:0] illegalCount;

	integer seed;
	logic [31:0] model [0:31];
	wbT expQ [$];
	logic [5:0] fnList [0:7];
	string testName;
	int errorCount;
	int checkCount;
	int testsRun;
	int testsFailed;
	int testErrStart;

	datapathCore dut_i (
		.clock(clock),
		.rst(rst),
		.instr(instr),
		.instrValid(instrValid),
		.result(result),
		.resultValid(resultValid),
		.retiredCount(retiredCount),
		.illegalCount(illegalCount)
	);

	initial
	begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	function automatic logic [31:0] randWord();
		return $random(seed);
	endfunction

	function automatic logic [4:0] randReg();
		logic [31:0] w;
		w = randWord();
		while (w[4:0] == 5'd0)
			w = randWord();
		return w[4:0];
	endfunction

	function automatic logic isDefinedOp(input logic [5:0] op);
		return op == `OP_RTYPE || op == `OP_ADDI || op == `OP_ANDI || op == `OP_ORI
			|| op == `OP_LUI;
	endfunction

	function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {`OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// expected writeback straight from the MIPS field and extension rules
	function automatic wbT refModel(input logic [31:0] ins, input logic [31:0] regs [0:31]);
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0] sh;
		wbT r;
		a = regs[ins[25:21]];
		b = regs[ins[20:16]];
		sh = ins[10:6];
		r.dest = (ins[31:26] == `OP_RTYPE) ? ins[15:11] : ins[20:16];
		r.data = 32'd0;
		r.illegal = 1'b0;
		case (ins[31:26])
			`OP_RTYPE:
			begin
				case (ins[5:0])
					`FN_ADD: r.data = a + b;
					`FN_SUB: r.data = a - b;
					`FN_AND: r.data = a & b;
					`FN_OR: r.data = a | b;
					`FN_XOR: r.data = a ^ b;
					`FN_SLT: r.data = {31'd0, $signed(a) < $signed(b)};
					`FN_SLL: r.data = b << sh;
					`FN_SRL: r.data = b >> sh;
					default: r.illegal = 1'b1;
				endcase
			end
			`OP_ADDI: r.data = a + {{16{ins[15]}}, ins[15:0]};
			`OP_ANDI: r.data = a & {16'd0, ins[15:0]};
			`OP_ORI: r.data = a | {16'd0, ins[15:0]};
			`OP_LUI: r.data = {ins[15:0], 16'd0};
			default: r.illegal = 1'b1;
		endcase
		r.regWrite = !r.illegal && (r.dest != 5'd0);
		return r;
	endfunction

	task automatic checkEqual(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			$display("[FAIL] %s %s: expected %h, actual %h", testName, what, expected, actual);
		end
	endtask

	// the model moves at issue time, so later instructions see the value they depend on
	task automatic issue(input logic [31:0] ins);
		wbT e;
		@(posedge clock);
		instr <= ins;
		instrValid <= 1'b1;
		e = refModel(ins, model);
		expQ.push_back(e);
		if (e.regWrite)
			model[e.dest] = e.data;
	endtask

	task automatic drainPipe();
		@(posedge clock);
		instrValid <= 1'b0;
		instr <= 32'd0;
		while (expQ.size() != 0)
			@(negedge clock);
		@(negedge clock);
	endtask

	task automatic beginTest(input string name);
		testName = name;
		testErrStart = errorCount;
	endtask

	task automatic endTest();
		testsRun++;
		if (errorCount != testErrStart)
		begin
			testsFailed++;
			$display("%s: %0d errors", testName, errorCount - testErrStart);
		end
		else
			$display("%s: ok", testName);
	endtask

	always @(negedge clock)
	begin : compare
		wbT expWb;
		if (!rst && resultValid)
		begin
			if (expQ.size() == 0)
			begin
				errorCount++;
				$display("a result came out with no instruction outstanding in %s", testName);
			end
			else
			begin
				expWb = expQ.pop_front();
				checkEqual("result", 64'(expWb), 64'(result));
			end
		end
	end

	initial
	begin
		#((TOTAL_INSTR + 50) * CLK_PERIOD);
		$display("watchdog ran out before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		logic [31:0] w;
		logic [31:0] w2;
		logic [31:0] countStart;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] rd;
		logic [5:0] op;
		seed = 32'h3b37;
		rst = 1'b1;
		instr = 32'd0;
		instrValid = 1'b0;
		errorCount = 0;
		checkCount = 0;
		testsRun = 0;
		testsFailed = 0;
		fnList = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_XOR, `FN_SLT, `FN_SLL, `FN_SRL};
		for (int i = 0; i < 32; i++)
			model[i] = 32'd0;
		repeat (3) @(posedge clock);
		rst <= 1'b0;

		beginTest("reset state");
		repeat (6)
		begin
			@(negedge clock);
			checkEqual("idle resultValid", 64'd0, 64'(resultValid));
		end
		checkEqual("retiredCount", 64'd0, 64'(retiredCount));
		checkEqual("illegalCount", 64'd0, 64'(illegalCount));
		for (int k = 0; k < 32; k++)
			issue(rType(`FN_OR, 5'(k), 5'd0, 5'(k), 5'd0));
		drainPipe();
		endTest();

		beginTest("immediate operations");
		for (int rep = 0; rep < 4; rep++)
		begin
			ra = randReg();
			rb = randReg();
			w = randWord();
			issue(iType(`OP_LUI, 5'd0, ra, w[15:0]));
			issue(rType(`FN_OR, ra, 5'd0, ra, 5'd0));
			issue(iType(`OP_ORI, rb, ra, w[31:16]));
			issue(rType(`FN_OR, ra, 5'd0, ra, 5'd0));
			issue(iType(`OP_ADDI, ra, rb, {1'b1, w[14:0]})); // always negative
			issue(rType(`FN_OR, rb, 5'd0, rb, 5'd0));
			issue(iType(`OP_ANDI, rb, ra, w[30:15]));
			issue(rType(`FN_OR, ra, 5'd0, ra, 5'd0));
		end
		drainPipe();
		endTest();

		beginTest("register operations");
		for (int rep = 0; rep < 3; rep++)
		begin
			for (int f = 0; f < 8; f++)
			begin
				ra = randReg();
				rb = randReg();
				while (rb == ra)
					rb = randReg();
				rd = randReg();
				w = randWord();
				w2 = randWord();
				if (fnList[f] == `FN_SLT)
					w2[31] = ~w[31]; // operands of opposite sign
				issue(iType(`OP_LUI, 5'd0, ra, w[31:16]));
				issue(iType(`OP_ORI, ra, ra, w[15:0]));
				issue(iType(`OP_LUI, 5'd0, rb, w2[31:16]));
				issue(iType(`OP_ORI, rb, rb, w2[15:0]));
				w = randWord();
				issue(rType(fnList[f], ra, rb, rd, w[4:0]));
			end
		end
		drainPipe();
		endTest();

		beginTest("back-to-back dependencies");
		for (int d = 1; d <= 3; d++)
		begin
			for (int rep = 0; rep < 3; rep++)
			begin
				w = randWord();
				issue(iType(`OP_ADDI, 5'd5, 5'd5, w[15:0]));
				for (int k = 1; k < d; k++)
					issue(iType(`OP_ADDI, 5'd21, 5'd20, w[31:16])); // unrelated filler
				issue(rType(`FN_ADD, 5'd5, 5'd5, 5'd6, 5'd0));
			end
		end
		drainPipe();
		endTest();

		beginTest("register 0 and illegal encodings");
		countStart = illegalCount;
		for (int rep = 0; rep < 2; rep++)
		begin
			w = randWord();
			issue(iType(`OP_ADDI, 5'd1, 5'd0, w[15:0]));
			issue(rType(`FN_OR, 5'd0, 5'd0, 5'd7, 5'd0));
		end
		for (int k = 0; k < 4; k++)
		begin
			w = randWord();
			op = w[31:26];
			while (isDefinedOp(op))
			begin
				w = randWord();
				op = w[31:26];
			end
			issue({op, w[25:0]});
		end
		issue(rType(6'd63, 5'd1, 5'd2, 5'd3, 5'd0));
		drainPipe();
		checkEqual("illegalCount delta", 64'd5, 64'(illegalCount - countStart));
		endTest();

		beginTest("random stream");
		countStart = retiredCount;
		for (int n = 0; n < 300; n++)
		begin
			w = randWord();
			w2 = randWord();
			case (w[3:0])
				4'd8: issue({`OP_ADDI, w2[25:0]});
				4'd9: issue({`OP_ANDI, w2[25:0]});
				4'd10: issue({`OP_ORI, w2[25:0]});
				4'd11: issue({`OP_LUI, w2[25:0]});
				4'd15: issue({6'd63, w2[25:0]});
				default: issue({`OP_RTYPE, w2[25:6], fnList[w[6:4]]});
			endcase
		end
		drainPipe();
		checkEqual("retiredCount delta", 64'd300, 64'(retiredCount - countStart));
		endTest();

		if (expQ.size() != 0)
		begin
			errorCount++;
			$display("%0d expected results never came out", expQ.size());
		end
		$display("tests %0d, failed %0d, checks %0d, errors %0d", testsRun, testsFailed,
			checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* datapathCore.f */
+incdir+hw
hw/cpuPkg.sv
hw/registerFile.sv
hw/pipeStage.sv
hw/instrDecoder.sv
hw/aluExecute.sv
hw/resultStage.sv
hw/datapathCore.sv
verif/datapathCore_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the datapath testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module datapathCore_tb \
	-f datapathCore.f \
	-o simDatapath
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/simDatapath)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "TEST PASSED"; then
	exit 0
fi
exit 1
